// ==== wasm_core.f ====
+incdir+hw
hw/wasm_pkg.sv
hw/prog_mem.sv
hw/leb128_decoder.sv
hw/operand_stack.sv
hw/value_alu.sv
hw/exec_control.sv
hw/wasm_core.sv
verif/tb_clock.sv
verif/wasm_core_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= wasm_core_tb
FILELIST  ?= wasm_core.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it and check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q -F '*** FAILED ***' $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q -F '*** PASSED ***' $(LOG) || { echo "Simulation gave no result"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== verif/wasm_core_tb.sv ====
`include "wasm_core_settings.svh"

module wasm_core_tb;

  import wasm_pkg::*;

  localparam int MEM_BYTES  = 1 << `WASM_PROG_ADDR_W;
  localparam int MAX_CYCLES = 300;

  logic       clk;
  logic       reset;
  prog_addr_t entry_pc;
  logic       prog_we;
  prog_addr_t prog_addr;
  prog_byte_t prog_data;
  value_t     result;
  val_tag_t   result_type;
  logic       result_empty;
  trap_t      trap;

  // Program image, copied into the core under reset
  prog_byte_t prog_img [MEM_BYTES];
  int         plen;
  prog_addr_t entry;

  int   errors;
  int   errors_at_start;
  int   tests_run;
  int   tests_failed;
  logic hung;

  tb_clock tb_clock_i (
    .clk (clk)
  );

  wasm_core wasm_core_i (
    .clk          (clk),
    .reset        (reset),
    .entry_pc     (entry_pc),
    .prog_we      (prog_we),
    .prog_addr    (prog_addr),
    .prog_data    (prog_data),
    .result       (result),
    .result_type  (result_type),
    .result_empty (result_empty),
    .trap         (trap)
  );

  task automatic check_value(input string what, input logic [63:0] got,
                             input logic [63:0] exp);
    if (!hung && got !== exp) begin
      errors++;
      $display("error at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  // Zero image with address-dependent filler below the entry point
  task automatic new_program(input int start);
    for (int a = 0; a < MEM_BYTES; a++) begin
      prog_img[a] = (a < start) ? prog_byte_t'(a * 37 + 11) : 8'h00;
    end
    plen  = start;
    entry = prog_addr_t'(start);
  endtask

  task automatic emit(input prog_byte_t b);
    prog_img[plen] = b;
    plen++;
  endtask

  // Signed LEB128 in its shortest form
  task automatic emit_sleb(input logic [63:0] v);
    logic signed [63:0] x;
    prog_byte_t         b;
    logic               done;
    x    = v;
    done = 1'b0;
    while (!done) begin
      b    = {1'b0, x[6:0]};
      x    = x >>> 7;
      done = (x == '0 && !b[6]) || (x == '1 && b[6]);
      if (!done) begin
        b[7] = 1'b1;
      end
      emit(b);
    end
  endtask

  task automatic push_value(input logic is64, input logic [63:0] v);
    if (is64) begin
      emit(OP_I64_CONST);
      emit_sleb(v);
    end else begin
      emit(OP_I32_CONST);
      emit_sleb({{32{v[31]}}, v[31:0]});
    end
  endtask

  // Only nine immediate bytes fit the fetch window, so bits 63 and 62 agree
  function automatic logic [63:0] rand_i64();
    logic [63:0] v;
    v     = {$urandom, $urandom};
    v[63] = v[62];
    return v;
  endfunction

  // i32 payloads sit zero-extended on the stack
  function automatic logic [63:0] stack_value(input logic is64, input logic [63:0] v);
    return is64 ? v : {32'd0, v[31:0]};
  endfunction

  // Load the image under reset, hold 10 more cycles, then run until a trap
  task automatic run_program();
    int cycles;
    if (!hung) begin
      @(negedge clk);
      reset    = 1'b1;
      entry_pc = entry;
      for (int a = 0; a < MEM_BYTES; a++) begin
        prog_we   = 1'b1;
        prog_addr = prog_addr_t'(a);
        prog_data = prog_img[a];
        @(negedge clk);
      end
      prog_we = 1'b0;
      repeat (10) @(negedge clk);
      reset  = 1'b0;
      cycles = 0;
      while (trap == TRAP_NONE && cycles < MAX_CYCLES) begin
        @(negedge clk);
        cycles++;
      end
      if (trap == TRAP_NONE) begin
        hung = 1'b1;
        $display("timeout: the core did not halt within %0d cycles", MAX_CYCLES);
      end
    end
  endtask

  task automatic expect_trap(input trap_t t);
    check_value("trap", 64'(trap), 64'(t));
  endtask

  task automatic expect_top(input val_tag_t tag, input logic [63:0] v);
    check_value("result_type", 64'(result_type), 64'(tag));
    check_value("result", result, v);
    check_value("result_empty", 64'(result_empty), 64'd0);
  endtask

  task automatic expect_empty();
    check_value("result_empty", 64'(result_empty), 64'd1);
  endtask

  task automatic begin_test();
    errors_at_start = errors;
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (hung) begin
      tests_failed++;
      $display("test %s: core hung", name);
    end else if (errors != errors_at_start) begin
      tests_failed++;
      $display("test %s: failed, %0d errors", name, errors - errors_at_start);
    end else begin
      $display("test %s: ok", name);
    end
  endtask

  task automatic const_case(input logic is64, input logic [63:0] v);
    new_program(0);
    push_value(is64, v);
    emit(OP_END);
    run_program();
    expect_trap(TRAP_ENDED);
    expect_top(is64 ? TAG_I64 : TAG_I32, stack_value(is64, v));
  endtask

  task automatic binary_case(input opcode_t op, input logic is64,
                             input logic [63:0] a, input logic [63:0] b,
                             input val_tag_t tag, input logic [63:0] exp);
    new_program(0);
    push_value(is64, a);
    push_value(is64, b);
    emit(op);
    emit(OP_END);
    run_program();
    expect_trap(TRAP_ENDED);
    expect_top(tag, exp);
  endtask

  task automatic unary_case(input opcode_t op, input logic is64,
                            input logic [63:0] v, input logic [63:0] exp);
    new_program(0);
    push_value(is64, v);
    emit(op);
    emit(OP_END);
    run_program();
    expect_trap(TRAP_ENDED);
    expect_top(TAG_I32, exp);
  endtask

  // First pushed value wins when the condition is nonzero
  task automatic select_case(input logic is64, input logic [63:0] a,
                             input logic [63:0] b, input logic [31:0] cond);
    new_program(0);
    push_value(is64, a);
    push_value(is64, b);
    push_value(1'b0, 64'(cond));
    emit(OP_SELECT);
    emit(OP_END);
    run_program();
    expect_trap(TRAP_ENDED);
    expect_top(is64 ? TAG_I64 : TAG_I32, stack_value(is64, (cond != 0) ? a : b));
  endtask

  task automatic test_constants();
    begin_test();
    const_case(1'b0, 64'd63);
    const_case(1'b0, 64'hffff_ffff_ffff_ff80);
    const_case(1'b1, 64'hc000_0000_0000_0000);
    const_case(1'b1, 64'hffff_ffff_ffff_ffff);
    repeat (4) begin
      const_case(1'b0, {32'd0, $urandom});
      const_case(1'b1, rand_i64());
    end
    end_test("constants");
  endtask

  task automatic test_arithmetic();
    logic [63:0] a;
    logic [63:0] b;
    logic [31:0] x;
    logic [31:0] y;
    begin_test();
    repeat (4) begin
      x = $urandom;
      y = $urandom;
      binary_case(OP_I32_ADD, 1'b0, 64'(x), 64'(y), TAG_I32, {32'd0, x + y});
      binary_case(OP_I32_SUB, 1'b0, 64'(x), 64'(y), TAG_I32, {32'd0, x - y});
      a = rand_i64();
      b = rand_i64();
      binary_case(OP_I64_ADD, 1'b1, a, b, TAG_I64, a + b);
      binary_case(OP_I64_SUB, 1'b1, a, b, TAG_I64, a - b);
    end
    end_test("arithmetic");
  endtask

  task automatic test_comparisons();
    logic [63:0] a;
    logic [31:0] x;
    begin_test();
    x = $urandom;
    a = rand_i64();
    binary_case(OP_I32_EQ, 1'b0, 64'(x), 64'(x), TAG_I32, 64'd1);
    binary_case(OP_I32_EQ, 1'b0, 64'(x), 64'(x ^ 32'h0001_0000), TAG_I32, 64'd0);
    binary_case(OP_I32_NE, 1'b0, 64'(x), 64'(x), TAG_I32, 64'd0);
    binary_case(OP_I32_NE, 1'b0, 64'(x), 64'(x ^ 32'h1), TAG_I32, 64'd1);
    binary_case(OP_I64_EQ, 1'b1, a, a, TAG_I32, 64'd1);
    binary_case(OP_I64_EQ, 1'b1, a, a ^ 64'h100, TAG_I32, 64'd0);
    binary_case(OP_I64_NE, 1'b1, a, a, TAG_I32, 64'd0);
    binary_case(OP_I64_NE, 1'b1, a, a ^ 64'h1_0000_0000, TAG_I32, 64'd1);
    unary_case(OP_I32_EQZ, 1'b0, 64'd0, 64'd1);
    unary_case(OP_I32_EQZ, 1'b0, 64'(x | 32'h1), 64'd0);
    unary_case(OP_I64_EQZ, 1'b1, 64'd0, 64'd1);
    // Zero low word alone must not count as zero
    unary_case(OP_I64_EQZ, 1'b1, 64'h0000_0001_0000_0000, 64'd0);
    end_test("comparisons");
  endtask

  task automatic test_select_drop();
    logic [63:0] a;
    logic [63:0] b;
    logic [31:0] x;
    logic [31:0] y;
    begin_test();
    a = rand_i64();
    b = rand_i64();
    x = $urandom;
    y = $urandom;
    select_case(1'b1, a, b, 32'd5);
    select_case(1'b1, a, b, 32'd0);
    select_case(1'b0, 64'(x), 64'(y), 32'h8000_0000);
    select_case(1'b0, 64'(x), 64'(y), 32'd0);
    new_program(0);
    push_value(1'b1, a);
    push_value(1'b0, 64'(x));
    emit(OP_DROP);
    emit(OP_END);
    run_program();
    expect_trap(TRAP_ENDED);
    expect_top(TAG_I64, a);
    new_program(0);
    push_value(1'b0, 64'(x));
    emit(OP_DROP);
    emit(OP_END);
    run_program();
    expect_trap(TRAP_ENDED);
    expect_empty();
    end_test("select and drop");
  endtask

  task automatic test_traps();
    logic [63:0] a;
    logic [31:0] x;
    begin_test();
    a = rand_i64();
    x = $urandom;
    new_program(0);
    push_value(1'b0, 64'(x));
    push_value(1'b1, a);
    emit(OP_I32_ADD);
    emit(OP_END);
    run_program();
    expect_trap(TRAP_TYPE_MISMATCH);
    expect_top(TAG_I64, a);
    new_program(0);
    emit(OP_DROP);
    emit(OP_END);
    run_program();
    expect_trap(TRAP_STACK_EMPTY);
    expect_empty();
    // Eight entries fit, the ninth push traps
    new_program(0);
    for (int k = 1; k <= 9; k++) begin
      push_value(1'b0, 64'(k * 3));
    end
    emit(OP_END);
    run_program();
    expect_trap(TRAP_STACK_FULL);
    expect_top(TAG_I32, 64'd24);
    new_program(0);
    push_value(1'b0, 64'(x));
    emit(OP_UNREACHABLE);
    emit(OP_END);
    run_program();
    expect_trap(TRAP_UNREACHABLE);
    expect_top(TAG_I32, {32'd0, x});
    new_program(0);
    push_value(1'b1, a);
    emit(8'hff);
    emit(OP_END);
    run_program();
    expect_trap(TRAP_UNKNOWN_OPCODE);
    expect_top(TAG_I64, a);
    end_test("traps");
  endtask

  task automatic test_entry();
    logic [63:0] a;
    logic [63:0] b;
    begin_test();
    a = rand_i64();
    b = rand_i64();
    new_program(156);
    push_value(1'b1, a);
    emit(OP_NOP);
    push_value(1'b1, b);
    emit(OP_I64_SUB);
    emit(OP_END);
    run_program();
    expect_trap(TRAP_ENDED);
    expect_top(TAG_I64, a - b);
    end_test("entry address");
  endtask

  initial begin
    reset        = 1'b1;
    entry_pc     = '0;
    prog_we      = 1'b0;
    prog_addr    = '0;
    prog_data    = '0;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    hung         = 1'b0;
    plen         = 0;
    entry        = '0;
    void'($urandom(32'h6808));
    test_constants();
    if (!hung) test_arithmetic();
    if (!hung) test_comparisons();
    if (!hung) test_select_drop();
    if (!hung) test_traps();
    if (!hung) test_entry();
    $display("tests run %0d, tests failed %0d, check errors %0d",
             tests_run, tests_failed, errors);
    if (hung || errors != 0) begin
      $display("*** FAILED ***");
    end else begin
      $display("*** PASSED ***");
    end
    $finish;
  end

endmodule

// ==== verif/tb_clock.sv ====
module tb_clock (
  output logic clk
);

  // Period of 40 time units
  initial begin
    clk = 1'b0;
    forever begin
      #20 clk = ~clk;
    end
  end

endmodule

// ==== hw/wasm_core.sv ====
module wasm_core (
  input  logic                clk,
  input  logic                reset,
  input  wasm_pkg::prog_addr_t entry_pc,
  input  logic                prog_we,
  input  wasm_pkg::prog_addr_t prog_addr,
  input  wasm_pkg::prog_byte_t prog_data,
  output wasm_pkg::value_t     result,
  output wasm_pkg::val_tag_t   result_type,
  output logic                result_empty,
  output wasm_pkg::trap_t      trap
);

  import wasm_pkg::*;

  logic          fetch_en;
  prog_addr_t    fetch_addr;
  fetch_window_t fetch_window;
  value_t        imm_value;
  leb_len_t      imm_len;
  opcode_t       opcode;
  stack_op_t     stack_op;
  stack_entry_t  push_entry;
  stack_entry_t  tos;
  stack_entry_t  nos;
  stack_entry_t  third;
  stack_count_t  count;
  stack_entry_t  alu_entry;
  logic          alu_type_ok;

  assign {result_type, result} = tos;
  assign result_empty = count == '0;

  prog_mem prog_mem_i (
    .clk          (clk),
    .prog_we      (prog_we),
    .prog_addr    (prog_addr),
    .prog_data    (prog_data),
    .fetch_en     (fetch_en),
    .fetch_addr   (fetch_addr),
    .fetch_window (fetch_window)
  );

  // Immediate starts right after the opcode byte
  leb128_decoder leb128_decoder_i (
    .bytes (fetch_window[$bits(leb_bytes_t)-1:0]),
    .value (imm_value),
    .len   (imm_len)
  );

  operand_stack operand_stack_i (
    .clk        (clk),
    .reset      (reset),
    .op         (stack_op),
    .push_entry (push_entry),
    .tos        (tos),
    .nos        (nos),
    .third      (third),
    .count      (count)
  );

  value_alu value_alu_i (
    .opcode      (opcode),
    .tos         (tos),
    .nos         (nos),
    .third       (third),
    .alu_entry   (alu_entry),
    .alu_type_ok (alu_type_ok)
  );

  exec_control exec_control_i (
    .clk          (clk),
    .reset        (reset),
    .entry_pc     (entry_pc),
    .fetch_window (fetch_window),
    .imm_value    (imm_value),
    .imm_len      (imm_len),
    .count        (count),
    .alu_entry    (alu_entry),
    .alu_type_ok  (alu_type_ok),
    .fetch_en     (fetch_en),
    .fetch_addr   (fetch_addr),
    .opcode       (opcode),
    .stack_op     (stack_op),
    .push_entry   (push_entry),
    .trap         (trap)
  );

endmodule

// ==== hw/exec_control.sv ====
`include "wasm_core_settings.svh"

module exec_control (
  input  logic                   clk,
  input  logic                   reset,
  input  wasm_pkg::prog_addr_t    entry_pc,
  input  wasm_pkg::fetch_window_t fetch_window,
  input  wasm_pkg::value_t        imm_value,
  input  wasm_pkg::leb_len_t      imm_len,
  input  wasm_pkg::stack_count_t  count,
  input  wasm_pkg::stack_entry_t  alu_entry,
  input  logic                   alu_type_ok,
  output logic                   fetch_en,
  output wasm_pkg::prog_addr_t    fetch_addr,
  output wasm_pkg::opcode_t       opcode,
  output wasm_pkg::stack_op_t     stack_op,
  output wasm_pkg::stack_entry_t  push_entry,
  output wasm_pkg::trap_t         trap
);

  import wasm_pkg::*;

  localparam stack_count_t FULL_COUNT = stack_count_t'(1 << `WASM_STACK_DEPTH_W);

  exec_step_e   step;
  prog_addr_t   pc;
  prog_addr_t   pc_step;
  stack_count_t need;
  logic         grows;
  logic         uses_alu;
  logic         known;
  stack_op_t    dec_op;
  stack_entry_t const_entry;
  trap_t        exec_trap;

  assign opcode = fetch_window[$bits(fetch_window_t)-1 -: 8];

  // Operand needs and stack command per opcode
  always_comb begin
    need     = '0;
    grows    = 1'b0;
    uses_alu = 1'b0;
    known    = 1'b1;
    dec_op   = SOP_NONE;
    case (opcode)
      OP_UNREACHABLE, OP_NOP, OP_END: ;
      OP_DROP: begin
        need   = stack_count_t'(1);
        dec_op = SOP_POP;
      end
      OP_SELECT: begin
        need     = stack_count_t'(3);
        uses_alu = 1'b1;
        dec_op   = SOP_POP2_REPLACE;
      end
      OP_I32_CONST, OP_I64_CONST: begin
        grows  = 1'b1;
        dec_op = SOP_PUSH;
      end
      OP_I32_EQZ, OP_I64_EQZ: begin
        need     = stack_count_t'(1);
        uses_alu = 1'b1;
        dec_op   = SOP_REPLACE;
      end
      OP_I32_EQ, OP_I32_NE, OP_I64_EQ, OP_I64_NE,
      OP_I32_ADD, OP_I32_SUB, OP_I64_ADD, OP_I64_SUB: begin
        need     = stack_count_t'(2);
        uses_alu = 1'b1;
        dec_op   = SOP_POP1_REPLACE;
      end
      default: known = 1'b0;
    endcase
  end

  // Empty before full before type mismatch
  always_comb begin
    if (!known) begin
      exec_trap = TRAP_UNKNOWN_OPCODE;
    end else if (opcode == OP_UNREACHABLE) begin
      exec_trap = TRAP_UNREACHABLE;
    end else if (opcode == OP_END) begin
      exec_trap = TRAP_ENDED;
    end else if (count < need) begin
      exec_trap = TRAP_STACK_EMPTY;
    end else if (grows && count == FULL_COUNT) begin
      exec_trap = TRAP_STACK_FULL;
    end else if (uses_alu && !alu_type_ok) begin
      exec_trap = TRAP_TYPE_MISMATCH;
    end else begin
      exec_trap = TRAP_NONE;
    end
  end

  // i32 constants keep only the low word
  assign const_entry = (opcode == OP_I64_CONST) ? {TAG_I64, imm_value} :
                                                  {TAG_I32, 32'd0, imm_value[31:0]};

  assign pc_step = grows ? prog_addr_t'(imm_len) + prog_addr_t'(1) : prog_addr_t'(1);

  always_ff @(posedge clk) begin
    if (reset) begin
      step     <= STEP_FETCH;
      pc       <= entry_pc;
      trap     <= TRAP_NONE;
      fetch_en <= 1'b0;
      stack_op <= SOP_NONE;
    end else begin
      fetch_en <= 1'b0;
      stack_op <= SOP_NONE;
      case (step)
        STEP_FETCH: begin
          fetch_en <= 1'b1;
          step     <= STEP_WAIT;
        end
        STEP_WAIT: step <= STEP_EXEC;
        STEP_EXEC: begin
          if (exec_trap != TRAP_NONE) begin
            trap <= exec_trap;
            step <= STEP_HALT;
          end else begin
            stack_op <= dec_op;
            pc       <= pc + pc_step;
            step     <= STEP_FETCH;
          end
        end
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (step == STEP_FETCH) begin
      fetch_addr <= pc;
    end
    if (step == STEP_EXEC) begin
      push_entry <= grows ? const_entry : alu_entry;
    end
  end

  a_trap_held: assert property (@(posedge clk) disable iff (reset)
    step == STEP_HALT |=> $stable(trap));

endmodule

// ==== hw/value_alu.sv ====
module value_alu (
  input  wasm_pkg::opcode_t      opcode,
  input  wasm_pkg::stack_entry_t tos,
  input  wasm_pkg::stack_entry_t nos,
  input  wasm_pkg::stack_entry_t third,
  output wasm_pkg::stack_entry_t alu_entry,
  output logic                  alu_type_ok
);

  import wasm_pkg::*;

  val_tag_t tos_tag;
  val_tag_t nos_tag;
  val_tag_t third_tag;
  value_t   tos_val;
  value_t   nos_val;

  assign {tos_tag, tos_val} = tos;
  assign {nos_tag, nos_val} = nos;

  // Only the tag of the third entry takes part in the type check
  assign third_tag = third[$bits(stack_entry_t)-1 -: $bits(val_tag_t)];

  // Operands as nos (first pushed) and tos (second pushed)
  always_comb begin
    alu_type_ok = 1'b1;
    alu_entry   = tos;
    case (opcode)
      OP_I32_EQZ: begin
        alu_type_ok = tos_tag == TAG_I32;
        alu_entry   = {TAG_I32, value_t'(tos_val[31:0] == 32'd0)};
      end
      OP_I64_EQZ: begin
        alu_type_ok = tos_tag == TAG_I64;
        alu_entry   = {TAG_I32, value_t'(tos_val == 64'd0)};
      end
      OP_I32_EQ, OP_I32_NE: begin
        alu_type_ok = (nos_tag == TAG_I32) && (tos_tag == TAG_I32);
        alu_entry   = {TAG_I32, value_t'((nos_val[31:0] == tos_val[31:0]) ==
                                         (opcode == OP_I32_EQ))};
      end
      OP_I64_EQ, OP_I64_NE: begin
        alu_type_ok = (nos_tag == TAG_I64) && (tos_tag == TAG_I64);
        alu_entry   = {TAG_I32, value_t'((nos_val == tos_val) == (opcode == OP_I64_EQ))};
      end
      OP_I32_ADD, OP_I32_SUB: begin
        alu_type_ok = (nos_tag == TAG_I32) && (tos_tag == TAG_I32);
        alu_entry   = {TAG_I32, 32'd0, (opcode == OP_I32_ADD) ?
                       nos_val[31:0] + tos_val[31:0] : nos_val[31:0] - tos_val[31:0]};
      end
      OP_I64_ADD, OP_I64_SUB: begin
        alu_type_ok = (nos_tag == TAG_I64) && (tos_tag == TAG_I64);
        alu_entry   = {TAG_I64, (opcode == OP_I64_ADD) ?
                       nos_val + tos_val : nos_val - tos_val};
      end
      OP_SELECT: begin
        // Condition on top, the two candidates below it
        alu_type_ok = (tos_tag == TAG_I32) && (nos_tag == third_tag);
        alu_entry   = (tos_val[31:0] != 32'd0) ? third : nos;
      end
      default: ;
    endcase
  end

endmodule

// ==== hw/operand_stack.sv ====
`include "wasm_core_settings.svh"

module operand_stack (
  input  logic                  clk,
  input  logic                  reset,
  input  wasm_pkg::stack_op_t    op,
  input  wasm_pkg::stack_entry_t push_entry,
  output wasm_pkg::stack_entry_t tos,
  output wasm_pkg::stack_entry_t nos,
  output wasm_pkg::stack_entry_t third,
  output wasm_pkg::stack_count_t count
);

  import wasm_pkg::*;

  localparam int DW = `WASM_STACK_DEPTH_W;
  localparam int DEPTH = 1 << DW;

  stack_entry_t entries [DEPTH];

  logic [DW-1:0] idx1;
  logic [DW-1:0] idx2;
  logic [DW-1:0] idx3;
  logic [DW-1:0] idx_push;
  stack_count_t  need;

  // Slots of the top three entries, wrapping harmlessly when shallow
  assign idx_push = count[DW-1:0];
  assign idx1     = count[DW-1:0] - DW'(1);
  assign idx2     = count[DW-1:0] - DW'(2);
  assign idx3     = count[DW-1:0] - DW'(3);

  assign tos   = (count >= stack_count_t'(1)) ? entries[idx1] : '0;
  assign nos   = (count >= stack_count_t'(2)) ? entries[idx2] : '0;
  assign third = (count >= stack_count_t'(3)) ? entries[idx3] : '0;

  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
    end else begin
      case (op)
        SOP_PUSH:         count <= count + stack_count_t'(1);
        SOP_POP:          count <= count - stack_count_t'(1);
        SOP_POP1_REPLACE: count <= count - stack_count_t'(1);
        SOP_POP2_REPLACE: count <= count - stack_count_t'(2);
        default:          count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    case (op)
      SOP_PUSH:         entries[idx_push] <= push_entry;
      SOP_REPLACE:      entries[idx1] <= push_entry;
      SOP_POP1_REPLACE: entries[idx2] <= push_entry;
      SOP_POP2_REPLACE: entries[idx3] <= push_entry;
      default:          ;
    endcase
  end

  // Entries each command consumes or overwrites
  always_comb begin
    case (op)
      SOP_POP, SOP_REPLACE: need = stack_count_t'(1);
      SOP_POP1_REPLACE:     need = stack_count_t'(2);
      SOP_POP2_REPLACE:     need = stack_count_t'(3);
      default:              need = '0;
    endcase
  end

  // Controller must have checked room and depth before issuing
  a_push_not_full: assert property (@(posedge clk) disable iff (reset)
    op == SOP_PUSH |-> count < stack_count_t'(DEPTH));

  a_enough_entries: assert property (@(posedge clk) disable iff (reset)
    need <= count);

endmodule

// ==== hw/leb128_decoder.sv ====
`include "wasm_core_settings.svh"

module leb128_decoder (
  input  wasm_pkg::leb_bytes_t bytes,
  output wasm_pkg::value_t     value,
  output wasm_pkg::leb_len_t   len
);

  import wasm_pkg::*;

  localparam int NB = `WASM_FETCH_BYTES - 1;

  value_t     acc;
  logic       found;
  logic       sign;
  logic [6:0] ext_pos;
  prog_byte_t grp;

  always_comb begin
    acc     = '0;
    found   = 1'b0;
    sign    = 1'b0;
    ext_pos = '0;
    grp     = '0;
    // Unterminated encodings count as the full ten bytes
    len     = leb_len_t'(10);
    for (int i = 0; i < NB; i++) begin
      grp = bytes[(NB-1-i)*8 +: 8];
      if (!found) begin
        acc[7*i +: 7] = grp[6:0];
        if (!grp[7]) begin
          found   = 1'b1;
          sign    = grp[6];
          ext_pos = 7'(7 * (i + 1));
          len     = leb_len_t'(i + 1);
        end
      end
    end
  end

  // Sign bit of the last group fills everything above it
  assign value = (found && sign) ? (acc | (~64'd0 << ext_pos)) : acc;

endmodule

// ==== hw/prog_mem.sv ====
`include "wasm_core_settings.svh"

module prog_mem (
  input  logic                   clk,
  input  logic                   prog_we,
  input  wasm_pkg::prog_addr_t    prog_addr,
  input  wasm_pkg::prog_byte_t    prog_data,
  input  logic                   fetch_en,
  input  wasm_pkg::prog_addr_t    fetch_addr,
  output wasm_pkg::fetch_window_t fetch_window
);

  import wasm_pkg::*;

  localparam int AW        = `WASM_PROG_ADDR_W;
  localparam int FB        = `WASM_FETCH_BYTES;
  localparam int MEM_BYTES = 1 << AW;

  prog_byte_t mem [MEM_BYTES];

  // Load port, only used while the core is held in reset
  always_ff @(posedge clk) begin
    if (prog_we) begin
      mem[prog_addr] <= prog_data;
    end
  end

  // Ten bytes from fetch_addr, first byte on top
  always_ff @(posedge clk) begin
    if (fetch_en) begin
      for (int i = 0; i < FB; i++) begin
        if (int'(fetch_addr) + i < MEM_BYTES) begin
          fetch_window[(FB-1-i)*8 +: 8] <= mem[fetch_addr + prog_addr_t'(i)];
        end else begin
          // reads past the end give zero
          fetch_window[(FB-1-i)*8 +: 8] <= '0;
        end
      end
    end
  end

endmodule

// ==== hw/wasm_pkg.sv ====
`include "wasm_core_settings.svh"

package wasm_pkg;

  typedef logic [`WASM_PROG_ADDR_W-1:0] prog_addr_t;
  typedef logic [7:0] prog_byte_t;

  // Opcode byte sits in the top byte
  typedef logic [`WASM_FETCH_BYTES*8-1:0] fetch_window_t;

  // Window with the opcode byte removed
  typedef logic [(`WASM_FETCH_BYTES-1)*8-1:0] leb_bytes_t;

  typedef logic [1:0] val_tag_t;
  localparam val_tag_t TAG_I32 = 2'd0;
  localparam val_tag_t TAG_I64 = 2'd1;
  localparam val_tag_t TAG_F32 = 2'd2;
  localparam val_tag_t TAG_F64 = 2'd3;

  typedef logic [63:0] value_t;
  typedef logic [65:0] stack_entry_t;
  typedef logic [`WASM_STACK_DEPTH_W:0] stack_count_t;
  typedef logic [3:0] leb_len_t;

  // Standard WebAssembly encodings
  typedef logic [7:0] opcode_t;
  localparam opcode_t OP_UNREACHABLE = 8'h00;
  localparam opcode_t OP_NOP         = 8'h01;
  localparam opcode_t OP_END         = 8'h0b;
  localparam opcode_t OP_DROP        = 8'h1a;
  localparam opcode_t OP_SELECT      = 8'h1b;
  localparam opcode_t OP_I32_CONST   = 8'h41;
  localparam opcode_t OP_I64_CONST   = 8'h42;
  localparam opcode_t OP_I32_EQZ     = 8'h45;
  localparam opcode_t OP_I32_EQ      = 8'h46;
  localparam opcode_t OP_I32_NE      = 8'h47;
  localparam opcode_t OP_I64_EQZ     = 8'h50;
  localparam opcode_t OP_I64_EQ      = 8'h51;
  localparam opcode_t OP_I64_NE      = 8'h52;
  localparam opcode_t OP_I32_ADD     = 8'h6a;
  localparam opcode_t OP_I32_SUB     = 8'h6b;
  localparam opcode_t OP_I64_ADD     = 8'h7c;
  localparam opcode_t OP_I64_SUB     = 8'h7d;

  typedef logic [3:0] trap_t;
  localparam trap_t TRAP_NONE           = 4'd0;
  localparam trap_t TRAP_ENDED          = 4'd1;
  localparam trap_t TRAP_UNREACHABLE    = 4'd2;
  localparam trap_t TRAP_TYPE_MISMATCH  = 4'd3;
  localparam trap_t TRAP_STACK_EMPTY    = 4'd4;
  localparam trap_t TRAP_STACK_FULL     = 4'd5;
  localparam trap_t TRAP_UNKNOWN_OPCODE = 4'd6;

  // Pop-and-replace drops entries first, then overwrites the new top
  typedef logic [2:0] stack_op_t;
  localparam stack_op_t SOP_NONE         = 3'd0;
  localparam stack_op_t SOP_PUSH         = 3'd1;
  localparam stack_op_t SOP_POP          = 3'd2;
  localparam stack_op_t SOP_REPLACE      = 3'd3;
  localparam stack_op_t SOP_POP1_REPLACE = 3'd4;
  localparam stack_op_t SOP_POP2_REPLACE = 3'd5;

  typedef enum logic [1:0] {
    STEP_FETCH,
    STEP_WAIT,
    STEP_EXEC,
    STEP_HALT
  } exec_step_e;

endpackage

// ==== hw/wasm_core_settings.svh ====
`ifndef WASM_CORE_SETTINGS_SVH
`define WASM_CORE_SETTINGS_SVH

// Program memory address width, 256 bytes
`define WASM_PROG_ADDR_W 8

// Operand stack index width, 8 entries
`define WASM_STACK_DEPTH_W 3

// Bytes per instruction fetch, opcode plus immediate
`define WASM_FETCH_BYTES 10

`endif
